// ==== hdl/dcache_pkg.sv ====
package dcache_pkg;

  // ------------------------------------------------------------------
  // address and data geometry
  // ------------------------------------------------------------------
  localparam int unsigned ADDR_WIDTH   = 8;   // word addressed
  localparam int unsigned WORD_WIDTH   = 32;
  localparam int unsigned LINE_WORDS   = 4;
  localparam int unsigned OFFSET_WIDTH = 2;   // log2 of LINE_WORDS
  localparam int unsigned TAG_WIDTH    = ADDR_WIDTH - OFFSET_WIDTH;

  // ------------------------------------------------------------------
  // typed vectors
  // ------------------------------------------------------------------
  typedef logic [ADDR_WIDTH-1:0] addr_t;
  typedef logic [WORD_WIDTH-1:0] word_t;

  // word 0 of the line sits in the low bits
  typedef logic [LINE_WORDS*WORD_WIDTH-1:0] line_t;

  typedef logic [TAG_WIDTH-1:0] tag_t;         // line address
  typedef logic [OFFSET_WIDTH-1:0] offset_t;   // word within a line

  // ------------------------------------------------------------------
  // arbiter FSM
  // ------------------------------------------------------------------
  typedef enum logic [1:0] {
    arb_idle,      // waiting for a requester
    arb_wait_mem,  // grant held until the memory responds
    arb_release    // one cycle gap so the served cache sees its hit
  } arb_state_t;

endpackage

// ==== hdl/cache_req_if.sv ====
`timescale 1ns/1ps

// request bundle between one cache and the memory arbiter
interface cache_req_if import dcache_pkg::*; ();

  logic  req;    // level, held until the cache is served
  logic  store;
  addr_t addr;
  word_t wdata;
  logic  grant;  // high while this cache owns the memory

  modport cache (
    output req,
    output store,
    output addr,
    output wdata,
    input  grant
  );

  modport arbiter (
    input  req,
    input  store,
    input  addr,
    input  wdata,
    output grant
  );

endinterface

// ==== hdl/line_store.sv ====
`timescale 1ns/1ps

module line_store import dcache_pkg::*; #(
  parameter int unsigned ENTRY_BITS = 2
) (
  input  logic  clk,
  input  logic  arst_n,
  input  tag_t  lookup_tag,
  input  logic  fill_en,
  input  line_t fill_line,
  input  logic  inval_en,
  input  tag_t  inval_tag,
  output logic  hit,
  output line_t rdata
);

  localparam int unsigned N_ENTRIES = 1 << ENTRY_BITS;

  logic [N_ENTRIES-1:0]  valid_q;
  tag_t                  tag_q  [N_ENTRIES];
  line_t                 data_q [N_ENTRIES];
  logic [ENTRY_BITS-1:0] victim_q;   // oldest entry, next to be replaced
  logic [ENTRY_BITS-1:0] fill_idx;
  logic                  free_found;

  // ------------------------------------------------------------------
  // parallel tag compare
  // ------------------------------------------------------------------
  always_comb begin
    hit   = 1'b0;
    rdata = '0;
    for (int i = 0; i < N_ENTRIES; i++) begin
      if (valid_q[i] && tag_q[i] == lookup_tag) begin
        hit   = 1'b1;
        rdata = data_q[i];   // tags are unique, at most one match
      end
    end
  end

  // ------------------------------------------------------------------
  // fill target, an empty slot wins over the FIFO victim
  // ------------------------------------------------------------------
  always_comb begin
    fill_idx   = victim_q;
    free_found = 1'b0;
    for (int i = 0; i < N_ENTRIES; i++) begin
      if (!free_found && !valid_q[i]) begin
        fill_idx   = i[ENTRY_BITS-1:0];
        free_found = 1'b1;
      end
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      valid_q  <= '0;
      victim_q <= '0;
    end else begin
      if (inval_en) begin
        for (int i = 0; i < N_ENTRIES; i++) begin
          if (tag_q[i] == inval_tag) begin
            valid_q[i] <= 1'b0;
          end
        end
      end
      if (fill_en) begin
        valid_q[fill_idx] <= 1'b1;
        victim_q          <= victim_q + 1'b1;   // wraps around the entries
      end
    end
  end

  // the line being filled is the one the port is still looking up
  always_ff @(posedge clk) begin
    if (fill_en) begin
      tag_q[fill_idx]  <= lookup_tag;
      data_q[fill_idx] <= fill_line;
    end
  end

endmodule

// ==== hdl/dcache.sv ====
`timescale 1ns/1ps

module dcache import dcache_pkg::*; #(
  parameter int unsigned ENTRY_BITS = 2
) (
  input  logic        clk,
  input  logic        arst_n,
  input  logic        enable,
  input  logic        store,
  input  addr_t       addr,
  input  word_t       data_in,
  input  logic        fill_valid,
  input  line_t       fill_line,
  input  logic        snoop_valid,
  input  tag_t        snoop_tag,
  cache_req_if.cache  bus,
  output logic        hit,
  output word_t       data_out
);

  tag_t    tag;
  offset_t offset;
  logic    ls_hit;
  line_t   ls_rdata;
  logic    served;          // memory response for this cache
  logic    fill_en;
  logic    own_store_done;
  logic    inval_en;
  tag_t    inval_tag;

  assign tag    = addr[ADDR_WIDTH-1:OFFSET_WIDTH];
  assign offset = addr[OFFSET_WIDTH-1:0];

  // ------------------------------------------------------------------
  // response handling
  // ------------------------------------------------------------------
  assign served         = bus.grant & fill_valid;
  assign fill_en        = served & ~store;
  assign own_store_done = served & store;   // write-through, keep no copy

  // other ports' stores arrive as snoops
  assign inval_en  = snoop_valid | own_store_done;
  assign inval_tag = own_store_done ? tag : snoop_tag;

  line_store #(
    .ENTRY_BITS (ENTRY_BITS)
  ) u_store (
    .clk        (clk),
    .arst_n     (arst_n),
    .lookup_tag (tag),
    .fill_en    (fill_en),
    .fill_line  (fill_line),
    .inval_en   (inval_en),
    .inval_tag  (inval_tag),
    .hit        (ls_hit),
    .rdata      (ls_rdata)
  );

  // ------------------------------------------------------------------
  // request to the arbiter
  // ------------------------------------------------------------------
  assign bus.req   = enable & (store | ~ls_hit);   // stores always go out
  assign bus.store = store;
  assign bus.addr  = addr;
  assign bus.wdata = data_in;

  assign hit      = enable & (store ? own_store_done : ls_hit);
  assign data_out = ls_rdata[offset*WORD_WIDTH +: WORD_WIDTH];

endmodule

// ==== hdl/mem_arbiter.sv ====
`timescale 1ns/1ps

module mem_arbiter import dcache_pkg::*; #(
  parameter int unsigned N_PORTS = 4
) (
  input  logic        clk,
  input  logic        arst_n,
  input  logic        fill_valid,
  cache_req_if.arbiter ports [N_PORTS],
  output logic        mem_req,
  output logic        mem_store,
  output addr_t       mem_addr,
  output word_t       mem_wdata
);

  localparam int unsigned PTR_W = (N_PORTS > 1) ? $clog2(N_PORTS) : 1;

  arb_state_t         state_q;
  logic [N_PORTS-1:0] grant_q;    // one-hot
  logic [PTR_W-1:0]   last_q;     // last served port
  logic [N_PORTS-1:0] req_vec;
  logic [N_PORTS-1:0] store_vec;
  addr_t              addr_arr  [N_PORTS];
  word_t              wdata_arr [N_PORTS];
  logic [PTR_W-1:0]   pick;
  logic               pick_valid;
  logic               choose;     // a new grant starts on this edge

  // flatten the interface array
  for (genvar i = 0; i < N_PORTS; i++) begin : g_port
    assign req_vec[i]     = ports[i].req;
    assign store_vec[i]   = ports[i].store;
    assign addr_arr[i]    = ports[i].addr;
    assign wdata_arr[i]   = ports[i].wdata;
    assign ports[i].grant = grant_q[i];
  end

  // search starts one past the last served port
  always_comb begin
    int unsigned idx;
    pick       = '0;
    pick_valid = 1'b0;
    for (int unsigned k = 1; k <= N_PORTS; k++) begin
      idx = (int'(last_q) + k) % N_PORTS;
      if (!pick_valid && req_vec[idx]) begin
        pick       = idx[PTR_W-1:0];
        pick_valid = 1'b1;
      end
    end
  end

  // the served cache has dropped its request by the end of release
  assign choose = pick_valid && (state_q == arb_idle || state_q == arb_release);

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state_q <= arb_idle;
      grant_q <= '0;
      last_q  <= PTR_W'(N_PORTS - 1);   // port 0 goes first
      mem_req <= 1'b0;
    end else begin
      mem_req <= 1'b0;   // strobe
      case (state_q)
        arb_idle, arb_release: begin
          state_q <= arb_idle;
          if (choose) begin
            mem_req <= 1'b1;
            grant_q <= N_PORTS'(1) << pick;
            last_q  <= pick;
            state_q <= arb_wait_mem;
          end
        end
        arb_wait_mem: begin
          if (fill_valid) begin
            grant_q <= '0;
            state_q <= arb_release;
          end
        end
        default: state_q <= arb_idle;
      endcase
    end
  end

  // request fields travel with the strobe
  always_ff @(posedge clk) begin
    if (choose) begin
      mem_store <= store_vec[pick];
      mem_addr  <= addr_arr[pick];
      mem_wdata <= wdata_arr[pick];
    end
  end

endmodule

// ==== hdl/backing_memory.sv ====
`timescale 1ns/1ps

module backing_memory import dcache_pkg::*; #(
  parameter int unsigned MEM_LATENCY = 3
) (
  input  logic  clk,
  input  logic  arst_n,
  input  logic  mem_req,
  input  logic  mem_store,
  input  addr_t mem_addr,
  input  word_t mem_wdata,
  output logic  fill_valid,
  output line_t fill_line,
  output logic  snoop_valid,
  output tag_t  snoop_tag
);

  localparam int unsigned MEM_WORDS = 1 << ADDR_WIDTH;
  localparam int unsigned CNT_W     = $clog2(MEM_LATENCY + 1);

  word_t            mem_q [MEM_WORDS];
  logic             busy_q;
  logic [CNT_W-1:0] cnt_q;
  logic             acc_store_q;   // captured request
  addr_t            acc_addr_q;
  word_t            acc_wdata_q;
  tag_t             acc_tag;
  logic             done;

  assign acc_tag = acc_addr_q[ADDR_WIDTH-1:OFFSET_WIDTH];
  assign done    = busy_q && (cnt_q == CNT_W'(1));

  // ------------------------------------------------------------------
  // latency counter and storage
  // ------------------------------------------------------------------
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      busy_q      <= 1'b0;
      cnt_q       <= '0;
      fill_valid  <= 1'b0;
      snoop_valid <= 1'b0;
      for (int i = 0; i < MEM_WORDS; i++) begin
        mem_q[i] <= '0;
      end
    end else begin
      fill_valid  <= 1'b0;
      snoop_valid <= 1'b0;
      if (mem_req) begin
        busy_q <= 1'b1;
        cnt_q  <= CNT_W'(MEM_LATENCY);
      end else if (busy_q) begin
        cnt_q <= cnt_q - 1'b1;
        if (done) begin
          busy_q      <= 1'b0;
          fill_valid  <= 1'b1;          // response for loads and stores
          snoop_valid <= acc_store_q;
          if (acc_store_q) begin
            mem_q[acc_addr_q] <= acc_wdata_q;
          end
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (mem_req) begin
      acc_store_q <= mem_store;
      acc_addr_q  <= mem_addr;
      acc_wdata_q <= mem_wdata;
    end
    if (done) begin
      if (acc_store_q) begin
        snoop_tag <= acc_tag;
      end else begin
        for (int w = 0; w < LINE_WORDS; w++) begin
          fill_line[w*WORD_WIDTH +: WORD_WIDTH] <= mem_q[{acc_tag, w[OFFSET_WIDTH-1:0]}];
        end
      end
    end
  end

endmodule

// ==== hdl/multi_dcache.sv ====
`timescale 1ns/1ps

module multi_dcache import dcache_pkg::*; #(
  parameter int unsigned N_PORTS     = 4,
  parameter int unsigned ENTRY_BITS  = 2,
  parameter int unsigned MEM_LATENCY = 3
) (
  input  logic                       clk,
  input  logic                       arst_n,
  input  logic  [N_PORTS-1:0]        enable,
  input  logic  [N_PORTS-1:0]        store,
  input  addr_t [N_PORTS-1:0]        addr,
  input  word_t [N_PORTS-1:0]        data_in,
  output logic  [N_PORTS-1:0]        hit,
  output word_t [N_PORTS-1:0]        data_out
);

  // arbiter to memory
  logic  mem_req;
  logic  mem_store;
  addr_t mem_addr;
  word_t mem_wdata;

  // memory broadcast to every cache
  logic  fill_valid;
  line_t fill_line;
  logic  snoop_valid;
  tag_t  snoop_tag;

  cache_req_if req_bus [N_PORTS] ();

  // ------------------------------------------------------------------
  // one cache per load/store port
  // ------------------------------------------------------------------
  for (genvar p = 0; p < N_PORTS; p++) begin : g_cache
    dcache #(
      .ENTRY_BITS (ENTRY_BITS)
    ) u_dcache (
      .clk         (clk),
      .arst_n      (arst_n),
      .enable      (enable[p]),
      .store       (store[p]),
      .addr        (addr[p]),
      .data_in     (data_in[p]),
      .fill_valid  (fill_valid),
      .fill_line   (fill_line),
      .snoop_valid (snoop_valid),
      .snoop_tag   (snoop_tag),
      .bus         (req_bus[p]),
      .hit         (hit[p]),
      .data_out    (data_out[p])
    );
  end

  mem_arbiter #(
    .N_PORTS (N_PORTS)
  ) u_arbiter (
    .clk        (clk),
    .arst_n     (arst_n),
    .fill_valid (fill_valid),
    .ports      (req_bus),
    .mem_req    (mem_req),
    .mem_store  (mem_store),
    .mem_addr   (mem_addr),
    .mem_wdata  (mem_wdata)
  );

  backing_memory #(
    .MEM_LATENCY (MEM_LATENCY)
  ) u_memory (
    .clk         (clk),
    .arst_n      (arst_n),
    .mem_req     (mem_req),
    .mem_store   (mem_store),
    .mem_addr    (mem_addr),
    .mem_wdata   (mem_wdata),
    .fill_valid  (fill_valid),
    .fill_line   (fill_line),
    .snoop_valid (snoop_valid),
    .snoop_tag   (snoop_tag)
  );

endmodule

// ==== verification/multi_dcache_tb.sv ====
`timescale 1ns/1ps

module multi_dcache_tb import dcache_pkg::*; ();

  localparam int N_PORTS     = 4;
  localparam int ENTRY_BITS  = 2;
  localparam int MEM_LATENCY = 3;
  localparam int HALF_PERIOD = 50;
  localparam int TIMEOUT     = 50;                         // cycles per wait
  localparam int PAR_BOUND   = N_PORTS * (MEM_LATENCY + 3); // one lone-miss latency per port
  localparam int MAX_TESTS   = 80;
  localparam int EXP_MISS    = 0;
  localparam int EXP_HIT     = 1;
  localparam int EXP_ANY     = 2;                          // random traffic, no first-cycle check

  logic                clk;
  logic                arst_n;
  logic  [N_PORTS-1:0] enable;
  logic  [N_PORTS-1:0] store;
  addr_t [N_PORTS-1:0] addr;
  word_t [N_PORTS-1:0] data_in;
  logic  [N_PORTS-1:0] hit;
  word_t [N_PORTS-1:0] data_out;

  // stimulus table, entries sharing a nonzero batch id start together
  string name_tab  [MAX_TESTS];
  int    port_tab  [MAX_TESTS];
  bit    store_tab [MAX_TESTS];
  addr_t addr_tab  [MAX_TESTS];
  word_t data_tab  [MAX_TESTS];
  int    hit_tab   [MAX_TESTS];
  int    batch_tab [MAX_TESTS];
  int    n_entries;

  // results per entry
  bit    done_r      [MAX_TESTS];
  bit    first_hit_r [MAX_TESTS];
  int    cyc_r       [MAX_TESTS];
  word_t got_r       [MAX_TESTS];
  word_t exp_r       [MAX_TESTS];

  word_t model_mem [1 << ADDR_WIDTH];   // reference memory, every store applied
  int    n_pass;
  int    n_fail;
  bit    timed_out;

  multi_dcache #(
    .N_PORTS     (N_PORTS),
    .ENTRY_BITS  (ENTRY_BITS),
    .MEM_LATENCY (MEM_LATENCY)
  ) dut0 (
    .clk      (clk),
    .arst_n   (arst_n),
    .enable   (enable),
    .store    (store),
    .addr     (addr),
    .data_in  (data_in),
    .hit      (hit),
    .data_out (data_out)
  );

  always #(HALF_PERIOD) clk = ~clk;

  task automatic add_entry(input string nm, input int port, input bit st, input addr_t a,
                           input word_t d, input int exp_hit, input int batch);
    name_tab[n_entries]  = nm;
    port_tab[n_entries]  = port;
    store_tab[n_entries] = st;
    addr_tab[n_entries]  = a;
    data_tab[n_entries]  = d;
    hit_tab[n_entries]   = exp_hit;
    batch_tab[n_entries] = batch;
    n_entries++;
  endtask

  // ------------------------------------------------------------------
  // stimulus table
  // ------------------------------------------------------------------
  task automatic build_table();
    // cold miss, then a hit on the same line
    add_entry("reset_load_miss", 0, 1'b0, 8'h10, '0, EXP_MISS, 0);
    add_entry("reset_load_hit", 0, 1'b0, 8'h10, '0, EXP_HIT, 0);
    // own store drops the line
    add_entry("store_line_prefill", 0, 1'b0, 8'h21, '0, EXP_MISS, 0);
    add_entry("store_word", 0, 1'b1, 8'h20, 32'hA5A5_0001, EXP_MISS, 0);
    add_entry("load_after_store", 0, 1'b0, 8'h20, '0, EXP_MISS, 0);
    add_entry("neighbor_hit", 0, 1'b0, 8'h22, '0, EXP_HIT, 0);
    // store on port 0 snoops port 1's copy away
    add_entry("snoop_prefill", 1, 1'b0, 8'h31, '0, EXP_MISS, 0);
    add_entry("snoop_store", 0, 1'b1, 8'h31, 32'h5A5A_0031, EXP_MISS, 0);
    add_entry("snoop_reload", 1, 1'b0, 8'h31, '0, EXP_MISS, 0);
    // all ports miss in the same cycle
    for (int p = 0; p < N_PORTS; p++) begin
      add_entry($sformatf("par_seed_%0d", p), 2, 1'b1, addr_t'(8'h40 + 5 * p),
                32'hC0DE_0000 + p, EXP_MISS, 0);
    end
    for (int p = 0; p < N_PORTS; p++) begin
      add_entry($sformatf("par_load_%0d", p), p, 1'b0, addr_t'(8'h40 + 5 * p), '0, EXP_MISS, 1);
    end
    // five lines through four entries
    for (int k = 0; k < 5; k++) begin
      add_entry($sformatf("fifo_fill_%0d", k), 3, 1'b0, addr_t'(8'h80 + 4 * k), '0, EXP_MISS, 0);
    end
    add_entry("fifo_evicted", 3, 1'b0, 8'h80, '0, EXP_MISS, 0);
    add_entry("fifo_kept", 3, 1'b0, 8'h90, '0, EXP_HIT, 0);
    // random traffic over a small window so lines get shared
    for (int k = 0; k < 40; k++) begin
      add_entry($sformatf("rand_%0d", k), $urandom % N_PORTS, ($urandom % 3) == 0,
                addr_t'($urandom % 64), $urandom, EXP_ANY, 0);
    end
  endtask

  // drive one group of entries and wait for each port's hit
  task automatic run_group(input int first, input int last);
    int cycles;
    int left;
    int p;
    @(negedge clk);
    enable = '0;
    store  = '0;
    for (int k = first; k <= last; k++) begin
      p          = port_tab[k];
      enable[p]  = 1'b1;
      store[p]   = store_tab[k];
      addr[p]    = addr_tab[k];
      data_in[p] = data_tab[k];
      exp_r[k]   = model_mem[addr_tab[k]];
      done_r[k]  = 1'b0;
    end
    cycles = 0;
    left   = last - first + 1;
    while (left > 0 && !timed_out) begin
      #(HALF_PERIOD / 2);   // sample a quarter cycle ahead of the rising edge
      for (int k = first; k <= last; k++) begin
        p = port_tab[k];
        if (!done_r[k] && hit[p]) begin
          done_r[k]      = 1'b1;
          first_hit_r[k] = (cycles == 0);
          got_r[k]       = data_out[p];
          cyc_r[k]       = cycles;
          left--;
          if (store_tab[k]) begin
            model_mem[addr_tab[k]] = data_tab[k];
          end
        end
      end
      if (left > 0) begin
        if (cycles >= TIMEOUT) begin
          timed_out = 1'b1;
        end else begin
          @(negedge clk);
          for (int k = first; k <= last; k++) begin
            if (done_r[k]) begin
              enable[port_tab[k]] = 1'b0;   // served ports go quiet
            end
          end
          cycles++;
        end
      end
    end
  endtask

  task automatic check_entry(input int k);
    bit ok;
    ok = 1'b1;
    if (!done_r[k]) begin
      $display("%s: port %0d gave no hit within %0d cycles", name_tab[k], port_tab[k], TIMEOUT);
      ok = 1'b0;
    end else begin
      if (hit_tab[k] != EXP_ANY && int'(first_hit_r[k]) != hit_tab[k]) begin
        $display("MISMATCH %s first-cycle hit: expected %0d, actual %0d",
                 name_tab[k], hit_tab[k], first_hit_r[k]);
        ok = 1'b0;
      end
      if (!store_tab[k] && got_r[k] !== exp_r[k]) begin
        $display("MISMATCH %s data: expected %h, actual %h", name_tab[k], exp_r[k], got_r[k]);
        ok = 1'b0;
      end
      if (batch_tab[k] != 0 && cyc_r[k] > PAR_BOUND) begin
        $display("%s: port %0d needed %0d cycles, more than the bound of %0d",
                 name_tab[k], port_tab[k], cyc_r[k], PAR_BOUND);
        ok = 1'b0;
      end
    end
    if (ok) begin
      n_pass++;
      $display("ok    %s", name_tab[k]);
    end else begin
      n_fail++;
      $display("FAIL  %s", name_tab[k]);
    end
  endtask

  // ------------------------------------------------------------------
  // main sequence
  // ------------------------------------------------------------------
  initial begin
    int i;
    int j;
    clk       = 1'b0;
    arst_n    = 1'b0;
    enable    = '0;
    store     = '0;
    addr      = '0;
    data_in   = '0;
    n_entries = 0;
    n_pass    = 0;
    n_fail    = 0;
    timed_out = 1'b0;
    void'($urandom(32'h2394));
    for (int a = 0; a < (1 << ADDR_WIDTH); a++) begin
      model_mem[a] = '0;   // memory clears on reset
    end
    build_table();

    repeat (3) @(posedge clk);
    @(negedge clk);
    arst_n = 1'b1;

    i = 0;
    while (i < n_entries && !timed_out) begin
      j = i;
      if (batch_tab[i] != 0) begin
        while (j + 1 < n_entries && batch_tab[j + 1] == batch_tab[i]) begin
          j++;
        end
      end
      run_group(i, j);
      for (int k = i; k <= j; k++) begin
        check_entry(k);
      end
      i = j + 1;
    end

    @(negedge clk);
    enable = '0;
    store  = '0;
    $display("%0d tests run, %0d passed, %0d failed", n_pass + n_fail, n_pass, n_fail);
    if (n_fail == 0 && !timed_out) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

// ==== multi_dcache.f ====
hdl/dcache_pkg.sv
hdl/cache_req_if.sv
hdl/line_store.sv
hdl/dcache.sv
hdl/mem_arbiter.sv
hdl/backing_memory.sv
hdl/multi_dcache.sv
verification/multi_dcache_tb.sv

// ==== Bender.yml ====
package:
  name: multi_dcache

sources:
  # shared definitions first
  - hdl/dcache_pkg.sv
  - hdl/cache_req_if.sv
  # design
  - hdl/line_store.sv
  - hdl/dcache.sv
  - hdl/mem_arbiter.sv
  - hdl/backing_memory.sv
  - hdl/multi_dcache.sv
  # testbench
  - target: test
    files:
      - verification/multi_dcache_tb.sv
